// ==== src/exec_pkg.sv ====
package exec_pkg;

	localparam int DATA_W     = 32;
	localparam int IMM_W      = 15;
	localparam int REG_COUNT  = 32;
	localparam int REG_ADDR_W = 5;
	localparam int MEM_WORDS  = 256;
	localparam int MEM_ADDR_W = 8;    // Word index from address bits 9..2.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Major opcodes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [5:0] {
		LWI     = 6'b000100,
		LWIBI   = 6'b001100,    // Post-increment.
		SWI     = 6'b010100,
		SWIBI   = 6'b011100,    // Post-increment.
		TY_BASE = 6'b100000,
		ADDI    = 6'b101000,
		SUBRI   = 6'b101001,
		ANDI    = 6'b101010,
		XORI    = 6'b101011,
		ORI     = 6'b101100,
		SLTI    = 6'b101110,
		SLTSI   = 6'b101111
	} opcode_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// TY_BASE sub-opcodes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [4:0] {
		ADD   = 5'b00000,
		SUB   = 5'b00001,
		AND   = 5'b00010,
		XOR   = 5'b00011,
		OR    = 5'b00100,
		SLT   = 5'b00110,
		SLTS  = 5'b00111,
		SLLI  = 5'b01000,
		SRLI  = 5'b01001,
		SRAI  = 5'b01010,
		ROTRI = 5'b01011,
		SLL   = 5'b01100,
		SRL   = 5'b01101,
		SRA   = 5'b01110,
		SEB   = 5'b10000,
		SEH   = 5'b10001
	} sub_op_e;

	// Load/store sequencing in the execute stage.
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		ACCESS = 2'd1,
		RETIRE = 2'd2
	} bus_state_e;

endpackage

// ==== src/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if;
	import exec_pkg::*;

	logic              req;     // Held until ack.
	logic              we;
	logic [DATA_W-1:0] addr;    // Byte address.
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;   // Valid with ack.
	logic              ack;

	modport requester (
		output req, we, addr, wdata,
		input  rdata, ack
	);

	modport memory (
		input  req, we, addr, wdata,
		output rdata, ack
	);

endinterface

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  logic [31:0]       src1,
	input  logic [31:0]       src2,
	input  exec_pkg::opcode_e opcode,
	input  exec_pkg::sub_op_e sub_op,
	output logic [31:0]       result,
	output logic              overflow,
	output logic              illegal
);
	import exec_pkg::*;

	logic [DATA_W-1:0]   sum;
	logic [DATA_W-1:0]   diff;
	logic [DATA_W-1:0]   rdiff;
	logic [2*DATA_W-1:0] rot;
	logic [4:0]          shamt;
	logic                sum_ovf;
	logic                diff_ovf;
	logic                rdiff_ovf;

	assign shamt = src2[4:0];
	assign sum   = src1 + src2;
	assign diff  = src1 - src2;
	assign rdiff = src2 - src1;     // SUBRI.
	assign rot   = {src1, src1} >> shamt;

	// Signed overflow from operand and result signs.
	assign sum_ovf   = (src1[31] == src2[31]) && (sum[31] != src1[31]);
	assign diff_ovf  = (src1[31] != src2[31]) && (diff[31] != src1[31]);
	assign rdiff_ovf = (src2[31] != src1[31]) && (rdiff[31] != src2[31]);

	always_comb begin
		result   = '0;
		overflow = 1'b0;
		illegal  = 1'b0;
		case (opcode)
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// Register-register group.
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			TY_BASE: begin
				case (sub_op)
					ADD: begin
						result   = sum;
						overflow = sum_ovf;
					end
					SUB: begin
						result   = diff;
						overflow = diff_ovf;
					end
					AND:        result = src1 & src2;
					OR:         result = src1 | src2;
					XOR:        result = src1 ^ src2;
					SLT:        result = {31'b0, src1 < src2};
					SLTS:       result = {31'b0, $signed(src1) < $signed(src2)};
					SRL, SRLI:  result = src1 >> shamt;
					SLL, SLLI:  result = src1 << shamt;
					SRA, SRAI:  result = $signed(src1) >>> shamt;
					ROTRI:      result = rot[DATA_W-1:0];
					SEB:        result = {{24{src1[7]}}, src1[7:0]};
					SEH:        result = {{16{src1[15]}}, src1[15:0]};
					default:    illegal = 1'b1;
				endcase
			end

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// Immediate group.
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			ADDI: begin
				result   = sum;
				overflow = sum_ovf;
			end
			SUBRI: begin
				result   = rdiff;
				overflow = rdiff_ovf;
			end
			ANDI:  result = src1 & src2;
			ORI:   result = src1 | src2;
			XORI:  result = src1 ^ src2;
			SLTI:  result = {31'b0, src1 < src2};
			SLTSI: result = {31'b0, $signed(src1) < $signed(src2)};

			// Address sum only, never flags overflow.
			LWI, SWI, LWIBI, SWIBI: result = sum;

			default: illegal = 1'b1;
		endcase
	end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [exec_pkg::REG_ADDR_W-1:0] ra_addr,
	input  logic [exec_pkg::REG_ADDR_W-1:0] rb_addr,
	output logic [exec_pkg::DATA_W-1:0]     ra_data,
	output logic [exec_pkg::DATA_W-1:0]     rb_data,
	input  logic                            wa_en,
	input  logic [exec_pkg::REG_ADDR_W-1:0] wa_addr,
	input  logic [exec_pkg::DATA_W-1:0]     wa_data,
	input  logic                            wb_en,
	input  logic [exec_pkg::REG_ADDR_W-1:0] wb_addr,
	input  logic [exec_pkg::DATA_W-1:0]     wb_data
);
	import exec_pkg::*;

	logic [DATA_W-1:0] regs [REG_COUNT];

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wb_en)
				regs[wb_addr] <= wb_data;
			if (wa_en)
				regs[wa_addr] <= wa_data;   // Port A last, so it wins.
		end
	end

	// Load target and base register of a post-increment load must differ.
	a_write_conflict: assert property (@(posedge clk) disable iff (reset)
		wa_en && wb_en |-> wa_addr != wb_addr);

endmodule

// ==== src/exec_ctrl.sv ====
`timescale 1ns/1ps

module exec_ctrl (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            issue,
	input  exec_pkg::opcode_e               opcode,
	input  exec_pkg::sub_op_e               sub_op,
	input  logic [exec_pkg::REG_ADDR_W-1:0] rt,
	input  logic [exec_pkg::REG_ADDR_W-1:0] ra,
	input  logic [exec_pkg::REG_ADDR_W-1:0] rb,
	input  logic [exec_pkg::IMM_W-1:0]      imm,
	output logic                            busy,
	output logic                            retire,
	output logic [exec_pkg::REG_ADDR_W-1:0] retire_rt,
	output logic [exec_pkg::DATA_W-1:0]     retire_data,
	output logic                            retire_write,
	output logic                            overflow,
	output logic                            illegal,
	output logic [exec_pkg::REG_ADDR_W-1:0] ra_addr,
	output logic [exec_pkg::REG_ADDR_W-1:0] rb_addr,
	input  logic [exec_pkg::DATA_W-1:0]     ra_data,
	input  logic [exec_pkg::DATA_W-1:0]     rb_data,
	output logic                            wa_en,
	output logic [exec_pkg::REG_ADDR_W-1:0] wa_addr,
	output logic [exec_pkg::DATA_W-1:0]     wa_data,
	output logic                            wb_en,
	output logic [exec_pkg::REG_ADDR_W-1:0] wb_addr,
	output logic [exec_pkg::DATA_W-1:0]     wb_data,
	mem_bus_if.requester                    bus
);
	import exec_pkg::*;

	bus_state_e            state;
	opcode_e               opcode_q;
	sub_op_e               sub_op_q;
	logic [REG_ADDR_W-1:0] rt_q;
	logic [REG_ADDR_W-1:0] ra_q;
	logic [REG_ADDR_W-1:0] rb_q;
	logic [IMM_W-1:0]      imm_q;
	logic [DATA_W-1:0]     load_q;
	logic [DATA_W-1:0]     imm_sext;
	logic [DATA_W-1:0]     src2;
	logic [DATA_W-1:0]     alu_result;
	logic                  alu_overflow;
	logic                  alu_illegal;
	logic                  issue_mem;
	logic                  is_load;
	logic                  is_store;
	logic                  is_bi;
	logic                  retiring;

	assign issue_mem = opcode inside {LWI, SWI, LWIBI, SWIBI};
	assign is_load   = opcode_q inside {LWI, LWIBI};
	assign is_store  = opcode_q inside {SWI, SWIBI};
	assign is_bi     = opcode_q inside {LWIBI, SWIBI};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Issue capture and access sequencing.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= IDLE;
			opcode_q <= opcode_e'(0);
			sub_op_q <= sub_op_e'(0);
			rt_q     <= '0;
			ra_q     <= '0;
			rb_q     <= '0;
			imm_q    <= '0;
			load_q   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (issue) begin
						opcode_q <= opcode;
						sub_op_q <= sub_op;
						rt_q     <= rt;
						ra_q     <= ra;
						rb_q     <= rb;
						imm_q    <= imm;
						if (issue_mem)
							state <= ACCESS;
						else
							state <= RETIRE;   // ALU and unknown ops.
					end
				end
				ACCESS: begin
					if (bus.ack) begin
						load_q <= bus.rdata;
						state  <= RETIRE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Second operand.
	assign imm_sext = {{(DATA_W-IMM_W){imm_q[IMM_W-1]}}, imm_q};

	always_comb begin
		case (opcode_q)
			TY_BASE: begin
				if (sub_op_q inside {SRLI, SLLI, SRAI, ROTRI})
					src2 = DATA_W'(rb_q);    // Shift amount in the rb field.
				else
					src2 = rb_data;
			end
			ANDI, ORI, XORI:        src2 = DATA_W'(imm_q);
			LWI, SWI, LWIBI, SWIBI: src2 = {imm_sext[DATA_W-3:0], 2'b00};
			default:                src2 = imm_sext;
		endcase
	end

	alu alu0 (
		.src1     (ra_data),
		.src2     (src2),
		.opcode   (opcode_q),
		.sub_op   (sub_op_q),
		.result   (alu_result),
		.overflow (alu_overflow),
		.illegal  (alu_illegal)
	);

	assign ra_addr = ra_q;
	assign rb_addr = is_store ? rt_q : rb_q;   // Store data comes from rt.

	// Retire and writeback.
	assign retiring     = state == RETIRE;
	assign busy         = state != IDLE;
	assign retire       = retiring;
	assign retire_rt    = rt_q;
	assign retire_data  = is_load ? load_q : alu_result;
	assign retire_write = retiring && !alu_illegal && !is_store;
	assign overflow     = retiring && alu_overflow;
	assign illegal      = retiring && alu_illegal;

	assign wa_en   = retire_write;
	assign wa_addr = rt_q;
	assign wa_data = retire_data;
	assign wb_en   = retiring && is_bi;      // Base update.
	assign wb_addr = ra_q;
	assign wb_data = alu_result;

	assign bus.req   = state == ACCESS;
	assign bus.we    = is_store;
	assign bus.addr  = is_bi ? ra_data : alu_result;
	assign bus.wdata = rb_data;

	a_issue_idle: assert property (@(posedge clk) disable iff (reset)
		issue |-> !busy);

	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		bus.req && !bus.ack |=> bus.req && $stable(bus.we) && $stable(bus.addr)
			&& $stable(bus.wdata));

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
	input  logic         clk,
	input  logic         reset,
	mem_bus_if.memory    core_bus,
	mem_bus_if.memory    host_bus,
	mem_bus_if.requester mem_bus
);
	import exec_pkg::*;

	logic              host_pend;
	logic              host_we_q;
	logic [DATA_W-1:0] host_addr_q;
	logic [DATA_W-1:0] host_wdata_q;
	logic              locked;
	logic              owner_host;
	logic              sel_host;

	// Core first, unless a grant is already held.
	assign sel_host = locked ? owner_host : !core_bus.req;

	assign mem_bus.req   = core_bus.req || host_pend;
	assign mem_bus.we    = sel_host ? host_we_q : core_bus.we;
	assign mem_bus.addr  = sel_host ? host_addr_q : core_bus.addr;
	assign mem_bus.wdata = sel_host ? host_wdata_q : core_bus.wdata;

	assign core_bus.ack   = mem_bus.ack && !owner_host;
	assign host_bus.ack   = mem_bus.ack && owner_host;
	assign core_bus.rdata = mem_bus.rdata;
	assign host_bus.rdata = mem_bus.rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			host_pend    <= 1'b0;
			host_we_q    <= 1'b0;
			host_addr_q  <= '0;
			host_wdata_q <= '0;
			locked       <= 1'b0;
			owner_host   <= 1'b0;
		end else begin
			if (host_bus.req) begin    // Strobe, held here until ack.
				host_pend    <= 1'b1;
				host_we_q    <= host_bus.we;
				host_addr_q  <= host_bus.addr;
				host_wdata_q <= host_bus.wdata;
			end else if (host_bus.ack) begin
				host_pend <= 1'b0;
			end

			if (mem_bus.ack) begin
				locked <= 1'b0;
			end else if (mem_bus.req && !locked) begin
				locked     <= 1'b1;
				owner_host <= sel_host;
			end
		end
	end

	a_ack_owned: assert property (@(posedge clk) disable iff (reset)
		mem_bus.ack |-> locked);

endmodule

// ==== src/data_mem.sv ====
`timescale 1ns/1ps

module data_mem (
	input  logic      clk,
	input  logic      reset,
	mem_bus_if.memory bus
);
	import exec_pkg::*;

	logic [DATA_W-1:0]     mem [MEM_WORDS];
	logic [MEM_ADDR_W-1:0] idx;
	logic                  start;

	assign idx   = bus.addr[MEM_ADDR_W+1:2];
	assign start = bus.req && !bus.ack;   // Ack cycle is not a new request.

	always_ff @(posedge clk) begin
		if (start && bus.we)
			mem[idx] <= bus.wdata;
		if (start)
			bus.rdata <= mem[idx];
	end

	always_ff @(posedge clk) begin
		if (reset)
			bus.ack <= 1'b0;
		else
			bus.ack <= start;
	end

endmodule

// ==== src/exec_core.sv ====
`timescale 1ns/1ps

module exec_core (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            issue,
	input  exec_pkg::opcode_e               opcode,
	input  exec_pkg::sub_op_e               sub_op,
	input  logic [exec_pkg::REG_ADDR_W-1:0] rt,
	input  logic [exec_pkg::REG_ADDR_W-1:0] ra,
	input  logic [exec_pkg::REG_ADDR_W-1:0] rb,
	input  logic [exec_pkg::IMM_W-1:0]      imm,
	output logic                            busy,
	output logic                            retire,
	output logic [exec_pkg::REG_ADDR_W-1:0] retire_rt,
	output logic [exec_pkg::DATA_W-1:0]     retire_data,
	output logic                            retire_write,
	output logic                            overflow,
	output logic                            illegal,
	input  logic                            host_req,
	input  logic                            host_we,
	input  logic [exec_pkg::DATA_W-1:0]     host_addr,
	input  logic [exec_pkg::DATA_W-1:0]     host_wdata,
	output logic [exec_pkg::DATA_W-1:0]     host_rdata,
	output logic                            host_ack
);
	import exec_pkg::*;

	logic [REG_ADDR_W-1:0] ra_addr;
	logic [REG_ADDR_W-1:0] rb_addr;
	logic [DATA_W-1:0]     ra_data;
	logic [DATA_W-1:0]     rb_data;
	logic                  wa_en;
	logic [REG_ADDR_W-1:0] wa_addr;
	logic [DATA_W-1:0]     wa_data;
	logic                  wb_en;
	logic [REG_ADDR_W-1:0] wb_addr;
	logic [DATA_W-1:0]     wb_data;

	mem_bus_if core_bus ();
	mem_bus_if host_bus ();
	mem_bus_if mem_bus ();

	// Host side of the arbiter.
	assign host_bus.req   = host_req;
	assign host_bus.we    = host_we;
	assign host_bus.addr  = host_addr;
	assign host_bus.wdata = host_wdata;
	assign host_rdata     = host_bus.rdata;
	assign host_ack       = host_bus.ack;

	exec_ctrl ctrl0 (
		.*,
		.bus (core_bus)
	);

	reg_file rf0 (.*);

	mem_arbiter arb0 (
		.clk,
		.reset,
		.core_bus (core_bus),
		.host_bus (host_bus),
		.mem_bus  (mem_bus)
	);

	data_mem mem0 (
		.clk,
		.reset,
		.bus (mem_bus)
	);

endmodule

// ==== test/tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core;
	import exec_pkg::*;

	localparam int TIMEOUT = 20;

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  issue;
	opcode_e               opcode;
	sub_op_e               sub_op;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] ra;
	logic [REG_ADDR_W-1:0] rb;
	logic [IMM_W-1:0]      imm;
	logic                  busy;
	logic                  retire;
	logic [REG_ADDR_W-1:0] retire_rt;
	logic [DATA_W-1:0]     retire_data;
	logic                  retire_write;
	logic                  overflow;
	logic                  illegal;
	logic                  host_req;
	logic                  host_we;
	logic [DATA_W-1:0]     host_addr;
	logic [DATA_W-1:0]     host_wdata;
	logic [DATA_W-1:0]     host_rdata;
	logic                  host_ack;

	logic [DATA_W-1:0] regs [REG_COUNT];       // Register mirror.
	logic [DATA_W-1:0] mem_model [MEM_WORDS];
	logic [31:0]       lfsr = 32'he900_2ffe;
	int                checks = 0;
	int                errors = 0;

	always #20 clk = ~clk;

	exec_core dut0 (.*);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Random source and reporting.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] got,
			input logic [REG_ADDR_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout at %0t: %s", $time, what);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [DATA_W-1:0] model_alu(input opcode_e op, input sub_op_e sub,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
			output logic ovf, output logic ill);
		logic [DATA_W:0]   wide;
		logic [DATA_W-1:0] r;
		logic [4:0]        sh;
		sh   = b[4:0];
		r    = '0;
		ovf  = 1'b0;
		ill  = 1'b0;
		wide = '0;
		if (op == ADDI || (op == TY_BASE && sub == ADD))
			wide = {a[31], a} + {b[31], b};
		else if (op == SUBRI)
			wide = {b[31], b} - {a[31], a};   // Reversed operands.
		else if (op == TY_BASE && sub == SUB)
			wide = {a[31], a} - {b[31], b};
		case (op)
			ADDI, SUBRI: begin
				r   = wide[DATA_W-1:0];
				ovf = wide[32] ^ wide[31];
			end
			ANDI:  r = a & b;
			ORI:   r = a | b;
			XORI:  r = a ^ b;
			SLTI:  r = (a < b) ? 32'd1 : 32'd0;
			SLTSI: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			TY_BASE: begin
				case (sub)
					ADD, SUB: begin
						r   = wide[DATA_W-1:0];
						ovf = wide[32] ^ wide[31];
					end
					AND:       r = a & b;
					OR:        r = a | b;
					XOR:       r = a ^ b;
					SLT:       r = (a < b) ? 32'd1 : 32'd0;
					SLTS:      r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					SRL, SRLI: r = a >> sh;
					SLL, SLLI: r = a << sh;
					SRA, SRAI: begin
						r = a >> sh;
						if (a[31])
							r = r | ~(32'hffff_ffff >> sh);
					end
					ROTRI: begin
						for (int i = 0; i < DATA_W; i++)
							r[i] = a[(i + sh) % DATA_W];
					end
					SEB:     r = {{24{a[7]}}, a[7:0]};
					SEH:     r = {{16{a[15]}}, a[15:0]};
					default: ill = 1'b1;
				endcase
			end
			default: ill = 1'b1;
		endcase
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus drivers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic execute(input opcode_e op, input sub_op_e sub,
			input logic [REG_ADDR_W-1:0] rt_i, input logic [REG_ADDR_W-1:0] ra_i,
			input logic [REG_ADDR_W-1:0] rb_i, input logic [IMM_W-1:0] imm_i);
		logic [DATA_W-1:0] src1;
		logic [DATA_W-1:0] src2;
		logic [DATA_W-1:0] offset;
		logic [DATA_W-1:0] addr;
		logic [DATA_W-1:0] exp_data;
		logic              exp_ovf;
		logic              exp_ill;
		logic              exp_write;
		logic              mem_op;
		logic              store;
		int                waited;
		src1   = regs[ra_i];
		offset = {{(DATA_W-IMM_W){imm_i[IMM_W-1]}}, imm_i};
		mem_op = op inside {LWI, SWI, LWIBI, SWIBI};
		store  = op inside {SWI, SWIBI};
		addr   = (op inside {LWIBI, SWIBI}) ? src1 : src1 + (offset << 2);
		if (op == TY_BASE)
			src2 = (sub inside {SRLI, SLLI, SRAI, ROTRI}) ? DATA_W'(rb_i) : regs[rb_i];
		else if (op inside {ANDI, ORI, XORI})
			src2 = DATA_W'(imm_i);
		else
			src2 = offset;
		if (mem_op) begin
			exp_data = mem_model[addr[MEM_ADDR_W+1:2]];
			exp_ovf  = 1'b0;
			exp_ill  = 1'b0;
		end else begin
			exp_data = model_alu(op, sub, src1, src2, exp_ovf, exp_ill);
		end
		exp_write = !exp_ill && !store;

		@(posedge clk);
		issue  <= 1'b1;
		opcode <= op;
		sub_op <= sub;
		rt     <= rt_i;
		ra     <= ra_i;
		rb     <= rb_i;
		imm    <= imm_i;
		@(posedge clk);
		issue  <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (!retire && waited < TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		if (!retire) begin
			report_timeout($sformatf("no retire for opcode %s", op.name()));
		end else begin
			check_reg("retire_rt", retire_rt, rt_i);
			check_flag("retire_write", retire_write, exp_write);
			check_flag("illegal", illegal, exp_ill);
			check_flag("overflow", overflow, exp_ovf);
			check_flag("busy", busy, 1'b1);
			if (exp_write)
				check_data("retire_data", retire_data, exp_data);
			if (!mem_op && waited != 0) begin
				errors++;
				$display("Retire came %0d cycles late for a single-cycle op", waited);
			end

			if (store)
				mem_model[addr[MEM_ADDR_W+1:2]] = regs[rt_i];
			if (op inside {LWIBI, SWIBI})
				regs[ra_i] = src1 + (offset << 2);   // Post-increment base.
			if (exp_write)
				regs[rt_i] = exp_data;
		end
	endtask

	task automatic host_access(input logic we, input logic [DATA_W-1:0] addr,
			input logic [DATA_W-1:0] wdata);
		int waited;
		@(posedge clk);
		host_req   <= 1'b1;
		host_we    <= we;
		host_addr  <= addr;
		host_wdata <= wdata;
		@(posedge clk);
		host_req <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (!host_ack && waited < TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		if (!host_ack)
			report_timeout("host access got no ack");
		else if (we)
			mem_model[addr[MEM_ADDR_W+1:2]] = wdata;
		else
			check_data("host_rdata", host_rdata, mem_model[addr[MEM_ADDR_W+1:2]]);
	endtask

	// Builds a full word from zero in r0.
	task automatic set_reg(input logic [REG_ADDR_W-1:0] r, input logic [DATA_W-1:0] value);
		execute(ORI, ADD, r, 5'd0, 5'd0, {1'b0, value[31:18]});
		execute(TY_BASE, SLLI, r, r, 5'd9, '0);
		execute(ORI, ADD, r, r, 5'd0, {6'b0, value[17:9]});
		execute(TY_BASE, SLLI, r, r, 5'd9, '0);
		execute(ORI, ADD, r, r, 5'd0, {6'b0, value[8:0]});
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic load_registers();
		for (int i = 1; i < REG_COUNT; i++)
			execute(ADDI, ADD, 5'(i), 5'd0, 5'd0, IMM_W'(rand_bits(IMM_W)));
		execute(ADDI, ADD, 5'd0, 5'd0, 5'd0, IMM_W'(rand_bits(IMM_W)));
		execute(TY_BASE, XOR, 5'd0, 5'd0, 5'd0, '0);   // r0 back to zero.
	endtask

	task automatic test_base_ops();
		sub_op_e               ops [16];
		logic [REG_ADDR_W-1:0] pa [8];
		logic [REG_ADDR_W-1:0] pb [8];
		ops = '{ADD, SUB, AND, OR, XOR, SLT, SLTS, SRL, SLL, SRA,
			SRLI, SLLI, SRAI, ROTRI, SEB, SEH};
		pa  = '{5'd1, 5'd2, 5'd1, 5'd2, 5'd3, 5'd5, 5'd3, 5'd4};
		pb  = '{5'd2, 5'd1, 5'd1, 5'd2, 5'd4, 5'd3, 5'd6, 5'd0};
		set_reg(5'd1, 32'h8000_0000);
		set_reg(5'd2, 32'h7fff_ffff);
		set_reg(5'd3, rand_bits(32));
		set_reg(5'd4, rand_bits(32));
		set_reg(5'd5, 32'hffff_ffff);
		set_reg(5'd6, 32'd31);               // Register shift by 31.
		foreach (ops[k]) begin
			if (ops[k] inside {SRLI, SLLI, SRAI, ROTRI}) begin
				execute(TY_BASE, ops[k], 5'd10, 5'd1, 5'd0, '0);
				execute(TY_BASE, ops[k], 5'd10, 5'd3, 5'd31, '0);
				execute(TY_BASE, ops[k], 5'd10, 5'd4, 5'(rand_bits(5)), '0);
			end else begin
				foreach (pa[p])
					execute(TY_BASE, ops[k], 5'd10, pa[p], pb[p], '0);
			end
		end
		repeat (12) begin
			set_reg(5'd7, rand_bits(32));
			execute(TY_BASE, ops[4'(rand_bits(4))], 5'd10, 5'd7, 5'(rand_bits(3)), '0);
		end
	endtask

	task automatic test_imm_ops();
		opcode_e          ops [7];
		logic [IMM_W-1:0] imms [4];
		ops  = '{ADDI, SUBRI, ANDI, ORI, XORI, SLTI, SLTSI};
		imms = '{15'h7fff, 15'h4000, 15'h3fff, 15'h0000};
		foreach (ops[k]) begin
			foreach (imms[m])
				execute(ops[k], ADD, 5'd11, 5'd3, 5'd0, imms[m]);
			execute(ops[k], ADD, 5'd11, 5'd1, 5'd0, IMM_W'(rand_bits(IMM_W)));
			execute(ops[k], ADD, 5'd11, 5'd2, 5'd0, IMM_W'(rand_bits(IMM_W)));
		end
	endtask

	task automatic test_load_store();
		for (int i = 16; i < 24; i++)
			host_access(1'b1, DATA_W'(i * 4), rand_bits(32));
		execute(ADDI, ADD, 5'd12, 5'd0, 5'd0, 15'd64);     // Base at word 16.
		execute(LWI, ADD, 5'd13, 5'd12, 5'd0, 15'd3);
		execute(LWI, ADD, 5'd14, 5'd12, 5'd0, 15'd7);
		execute(ADDI, ADD, 5'd15, 5'd0, 5'd0, 15'd92);
		execute(LWI, ADD, 5'd16, 5'd15, 5'd0, 15'h7ffd);   // Offset of minus three words.
		execute(SWI, ADD, 5'd13, 5'd12, 5'd0, 15'd5);
		host_access(1'b0, 32'd84, '0);
		execute(LWIBI, ADD, 5'd17, 5'd12, 5'd0, 15'd2);
		execute(ADDI, ADD, 5'd18, 5'd12, 5'd0, 15'd0);
		execute(SWIBI, ADD, 5'd16, 5'd12, 5'd0, 15'h7fff);
		execute(ADDI, ADD, 5'd18, 5'd12, 5'd0, 15'd0);
		host_access(1'b0, 32'd72, '0);
		for (int i = 16; i < 24; i++)
			host_access(1'b0, DATA_W'(i * 4), '0);
	endtask

	task automatic test_arbitration();
		logic [DATA_W-1:0] exp_host;
		int                retire_at;
		int                ack_at;
		int                cycle;
		exp_host = regs[17];
		@(posedge clk);
		issue      <= 1'b1;
		opcode     <= SWI;
		sub_op     <= ADD;
		rt         <= 5'd17;
		ra         <= 5'd0;
		rb         <= 5'd0;
		imm        <= 15'd30;
		host_req   <= 1'b1;                   // Read of the word being stored.
		host_we    <= 1'b0;
		host_addr  <= 32'd120;
		host_wdata <= '0;
		@(posedge clk);
		issue    <= 1'b0;
		host_req <= 1'b0;
		retire_at = -1;
		ack_at    = -1;
		cycle     = 0;
		while ((retire_at < 0 || ack_at < 0) && cycle < TIMEOUT) begin
			@(negedge clk);
			if (retire) begin
				retire_at = cycle;
				check_flag("retire_write", retire_write, 1'b0);
			end
			if (host_ack) begin
				ack_at = cycle;
				check_data("host_rdata", host_rdata, exp_host);
			end
			cycle++;
		end
		if (retire_at < 0 || ack_at < 0) begin
			report_timeout("core store and host read did not both complete");
		end else if (ack_at <= retire_at) begin
			errors++;
			$display("Host read finished before the core store at %0t", $time);
		end
		mem_model[30] = exp_host;
	endtask

	task automatic test_illegal();
		execute(opcode_e'(6'h3f), ADD, 5'd5, 5'd1, 5'd2, '0);
		execute(TY_BASE, sub_op_e'(5'h1f), 5'd6, 5'd1, 5'd2, '0);
		execute(ADDI, ADD, 5'd19, 5'd5, 5'd0, '0);   // Reads back the untouched rt.
		execute(ADDI, ADD, 5'd20, 5'd6, 5'd0, '0);
	endtask

	initial begin
		reset      = 1'b1;
		issue      = 1'b0;
		opcode     = TY_BASE;
		sub_op     = ADD;
		rt         = '0;
		ra         = '0;
		rb         = '0;
		imm        = '0;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		foreach (regs[i])
			regs[i] = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("retire", retire, 1'b0);
		check_flag("host_ack", host_ack, 1'b0);

		load_registers();
		test_base_ops();
		test_imm_ops();
		test_load_store();
		test_arbitration();
		test_illegal();
		finish_run();
	end

endmodule

// ==== exec_core.f ====
src/exec_pkg.sv
src/mem_bus_if.sv
src/alu.sv
src/reg_file.sv
src/exec_ctrl.sv
src/mem_arbiter.sv
src/data_mem.sv
src/exec_core.sv
test/tb_exec_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_exec_core \
	-f exec_core.f -o sim_exec_core || { echo "Build failed."; exit 1; }
./obj_dir/sim_exec_core > sim.log 2>&1 || echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
